/* design/ctrl_xfer_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_xfr_fsm
  import dfu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  setup_pkt_u setup,
  input  logic       pkt_start,
  input  logic       pkt_end,
  input  out_ep_in_t out_ep,
  input  in_ep_in_t  in_ep_in,
  input  logic       source_empty,
  input  logic       stall,
  output logic       setup_end,
  output logic       data_end,
  output logic       status_end,
  output logic       in_req,
  output logic       in_put,
  output logic       in_done,
  output logic       out_get
);

  ctrl_stage_t stage;
  ctrl_stage_t stage_next;
  logic [15:0] remain;      // bytes left of wLength
  logic        has_data;
  logic        settle_q;    // read counters still loading
  logic        all_sent;
  logic        all_sent_q;
  logic        zlp;

  assign has_data = setup.fields.w_length != 16'd0;
  assign in_req   = (stage == DATA_IN) && !settle_q && (remain != 16'd0) && !source_empty;
  assign in_put   = in_req && in_ep_in.data_free;
  assign all_sent = (stage == DATA_IN) && !settle_q && !in_req;
  assign in_done  = (all_sent && !all_sent_q) || zlp;
  assign out_get  = out_ep.data_avail;

  ////////////////////////////////////////////////////////////////////////////
  // stage sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    stage_next = stage;
    setup_end  = 1'b0;
    data_end   = 1'b0;
    status_end = 1'b0;
    zlp        = 1'b0;
    case (stage)
      IDLE: begin
        if (pkt_start && out_ep.setup) stage_next = SETUP_IN;
      end
      SETUP_IN: begin
        if (pkt_end) stage_next = SETUP_DONE;
      end
      SETUP_DONE: begin
        setup_end = 1'b1;
        if (has_data && setup.fields.bm_request_type[7]) begin
          stage_next = DATA_IN;
        end else if (has_data) begin
          stage_next = DATA_OUT;
        end else begin
          stage_next = STATUS_IN;
          zlp        = 1'b1;  // no data stage, ack right away
        end
      end
      DATA_IN: begin
        if (stall) begin
          stage_next = IDLE;
          data_end   = 1'b1;
          status_end = 1'b1;
        end else if (in_ep_in.acked && all_sent) begin
          stage_next = STATUS_OUT;
          data_end   = 1'b1;
        end
      end
      DATA_OUT: begin
        if (remain == 16'd0) begin
          stage_next = STATUS_IN;
          data_end   = 1'b1;
          zlp        = 1'b1;
        end
      end
      STATUS_IN: begin
        if (in_ep_in.acked) begin
          stage_next = IDLE;
          status_end = 1'b1;
        end
      end
      STATUS_OUT: begin
        if (out_ep.acked) begin
          stage_next = IDLE;
          status_end = 1'b1;
        end
      end
      default: stage_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stage      <= IDLE;
      remain     <= 16'd0;
      settle_q   <= 1'b0;
      all_sent_q <= 1'b0;
    end else begin
      stage      <= stage_next;
      settle_q   <= setup_end;
      all_sent_q <= all_sent;
      if (setup_end) begin
        remain <= setup.fields.w_length;
      end else if (in_put && in_ep_in.grant) begin
        remain <= remain - 16'd1;
      end else if (!out_ep.setup && out_get && out_ep.grant && remain != 16'd0) begin
        remain <= remain - 16'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/dfu_ctrl_ep.sv */
`timescale 1ns/1ps
`default_nettype none

module dfu_ctrl_ep
  import dfu_pkg::*;
#(
  parameter int max_packet_size = 32,
  parameter int transfer_size   = 256
) (
  input  logic       clk,
  input  logic       reset,
  input  out_ep_in_t out_ep,
  input  in_ep_in_t  in_ep_in,
  output in_ep_out_t in_ep_out,
  output logic       out_ep_req,
  output logic       out_ep_data_get,
  output logic [6:0] dev_addr,
  output logic [7:0] dfu_state
);

  setup_pkt_u setup;
  read_plan_t plan;
  dfu_event_t dfu_event;
  dfu_state_e cur_state;
  logic       pkt_start;
  logic       pkt_end;
  logic       setup_end;
  logic       data_end;
  logic       status_end;
  logic       source_empty;
  logic       stall;
  logic       in_req;
  logic       in_put;
  logic       in_done;
  logic [7:0] in_data;
  logic [7:0] dfu_byte;
  logic [2:0] dfu_addr;
  logic       byte_moved;

  assign out_ep_req = out_ep.data_avail;
  assign dfu_state  = cur_state;
  assign byte_moved = in_put && in_ep_in.grant;
  assign in_ep_out  = '{req: in_req, data_put: in_put, data: in_data,
                        data_done: in_done, stall: stall};

  setup_capture u_setup_capture (
    .clk(clk), .reset(reset), .out_ep(out_ep), .status_end(status_end),
    .setup(setup), .pkt_start(pkt_start), .pkt_end(pkt_end)
  );

  ctrl_xfr_fsm u_ctrl_xfr_fsm (
    .clk(clk), .reset(reset), .setup(setup), .pkt_start(pkt_start), .pkt_end(pkt_end),
    .out_ep(out_ep), .in_ep_in(in_ep_in), .source_empty(source_empty), .stall(stall),
    .setup_end(setup_end), .data_end(data_end), .status_end(status_end),
    .in_req(in_req), .in_put(in_put), .in_done(in_done), .out_get(out_ep_data_get)
  );

  request_decoder u_request_decoder (
    .clk(clk), .reset(reset), .setup(setup), .setup_end(setup_end),
    .status_end(status_end), .dfu_state(cur_state), .plan(plan), .stall(stall),
    .dfu_event(dfu_event), .dev_addr(dev_addr)
  );

  dfu_state_tracker u_dfu_state_tracker (
    .clk(clk), .reset(reset), .dfu_event(dfu_event), .data_end(data_end),
    .addr(dfu_addr), .state(cur_state), .status_byte(dfu_byte)
  );

  in_data_source #(
    .max_packet_size(max_packet_size),
    .transfer_size(transfer_size)
  ) u_in_data_source (
    .clk(clk), .reset(reset), .plan(plan), .setup_end(setup_end),
    .status_end(status_end), .byte_moved(byte_moved), .dfu_byte(dfu_byte),
    .dfu_addr(dfu_addr), .source_empty(source_empty), .data(in_data)
  );

endmodule

`default_nettype wire

/* design/dfu_pkg.sv */
`default_nettype none

package dfu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // control transfer and setup packet
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    IDLE,
    SETUP_IN,
    SETUP_DONE,
    DATA_IN,
    DATA_OUT,
    STATUS_IN,
    STATUS_OUT
  } ctrl_stage_t;

  // top byte first, so bytes[0] lands on bm_request_type
  typedef struct packed {
    logic [15:0] w_length;
    logic [15:0] w_index;
    logic [15:0] w_value;
    logic [7:0]  b_request;
    logic [7:0]  bm_request_type;
  } setup_fields_t;

  typedef union packed {
    setup_fields_t   fields;
    logic [7:0][7:0] bytes;
  } setup_pkt_u;

  // {bmRequestType[6:5], bRequest}
  localparam logic [9:0] REQ_GET_DESCRIPTOR    = 10'h006;
  localparam logic [9:0] REQ_SET_ADDRESS       = 10'h005;
  localparam logic [9:0] REQ_SET_CONFIGURATION = 10'h009;
  localparam logic [9:0] REQ_DFU_DNLOAD        = 10'h101;
  localparam logic [9:0] REQ_DFU_GETSTATUS     = 10'h103;
  localparam logic [9:0] REQ_DFU_CLRSTATUS     = 10'h104;
  localparam logic [9:0] REQ_DFU_GETSTATE      = 10'h105;
  localparam logic [9:0] REQ_DFU_ABORT         = 10'h106;

  localparam logic [7:0] DESC_DEVICE    = 8'd1;
  localparam logic [7:0] DESC_CONFIG    = 8'd2;
  localparam logic [7:0] DESC_STRING    = 8'd3;
  localparam logic [7:0] DESC_QUALIFIER = 8'd6;

  localparam logic [7:0] ROM_DEVICE_ADDR = 8'd0;
  localparam logic [7:0] ROM_CONFIG_ADDR = 8'd18;
  localparam logic [7:0] ROM_LANG_ADDR   = 8'd45;

  ////////////////////////////////////////////////////////////////////////////
  // in data plan and DFU
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic {SRC_DESC, SRC_DFU} data_src_t;

  typedef struct packed {
    data_src_t  src;
    logic [7:0] addr;
    logic [7:0] len;
  } read_plan_t;

  typedef enum logic [2:0] {
    EV_NONE,
    EV_DNLOAD_BLOCK,
    EV_DNLOAD_FINAL,
    EV_DNLOAD_REJECT,
    EV_GETSTATUS,
    EV_CLRSTATUS,
    EV_ABORT
  } dfu_event_t;

  typedef enum logic [7:0] {
    DFU_IDLE          = 8'd2,
    DFU_DNLOAD_SYNC   = 8'd3,
    DFU_DNBUSY        = 8'd4,
    DFU_DNLOAD_IDLE   = 8'd5,
    DFU_MANIFEST_SYNC = 8'd6,
    DFU_ERROR         = 8'd10
  } dfu_state_e;

  localparam logic [7:0] DFU_STATUS_OK        = 8'h00;
  localparam logic [7:0] DFU_STATUS_ERR_WRITE = 8'h03;

  // endpoint strobes toward and from the packet engine
  typedef struct packed {
    logic       data_avail;
    logic       setup;
    logic       grant;
    logic       acked;
    logic [7:0] data;
  } out_ep_in_t;

  typedef struct packed {
    logic grant;
    logic data_free;
    logic acked;
  } in_ep_in_t;

  typedef struct packed {
    logic       req;
    logic       data_put;
    logic [7:0] data;
    logic       data_done;
    logic       stall;
  } in_ep_out_t;

endpackage

`default_nettype wire

/* design/dfu_state_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module dfu_state_tracker
  import dfu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  dfu_event_t dfu_event,
  input  logic       data_end,
  input  logic [2:0] addr,
  output dfu_state_e state,
  output logic [7:0] status_byte
);

  logic [7:0] status;

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= DFU_IDLE;
      status <= DFU_STATUS_OK;
    end else begin
      case (dfu_event)
        EV_DNLOAD_BLOCK: state <= DFU_DNBUSY;
        EV_DNLOAD_FINAL: begin
          state  <= DFU_MANIFEST_SYNC;
          status <= DFU_STATUS_OK;
        end
        EV_DNLOAD_REJECT: begin
          state  <= DFU_ERROR;
          status <= DFU_STATUS_ERR_WRITE;
        end
        EV_GETSTATUS: begin
          if (state == DFU_DNLOAD_SYNC) begin
            state <= DFU_DNLOAD_IDLE;
          end else if (state == DFU_MANIFEST_SYNC) begin
            state <= DFU_IDLE;
          end
        end
        EV_CLRSTATUS: begin
          state  <= DFU_IDLE;
          status <= DFU_STATUS_OK;
        end
        EV_ABORT: state <= DFU_IDLE;
        default: begin
          // block is done once its out data has all arrived
          if (data_end && state == DFU_DNBUSY) state <= DFU_DNLOAD_SYNC;
        end
      endcase
    end
  end

  // GETSTATUS reply: bStatus, bwPollTimeout[3], bState, iString
  always_comb begin
    case (addr)
      3'd0:    status_byte = status;
      3'd1:    status_byte = 8'd1;  // poll timeout 1 ms
      3'd4:    status_byte = state;
      default: status_byte = 8'd0;
    endcase
  end

endmodule

`default_nettype wire

/* design/in_data_source.sv */
`timescale 1ns/1ps
`default_nettype none

module in_data_source
  import dfu_pkg::*;
#(
  parameter int max_packet_size = 32,
  parameter int transfer_size   = 256
) (
  input  logic       clk,
  input  logic       reset,
  input  read_plan_t plan,
  input  logic       setup_end,
  input  logic       status_end,
  input  logic       byte_moved,
  input  logic [7:0] dfu_byte,
  output logic [2:0] dfu_addr,
  output logic       source_empty,
  output logic [7:0] data
);

  localparam int ROM_SIZE = 49;

  ////////////////////////////////////////////////////////////////////////////
  // descriptor ROM
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [7:0] ROM [ROM_SIZE] = '{
    // device, at ROM_DEVICE_ADDR
    8'd18, 8'h01, 8'h00, 8'h01,       // bLength, type, bcdUSB 1.00
    8'h00, 8'h00, 8'h00,              // class in interface
    8'(max_packet_size),              // bMaxPacketSize0
    8'h50, 8'h1d, 8'h30, 8'h61,       // idVendor, idProduct
    8'h00, 8'h00,                     // bcdDevice
    8'h00, 8'h00, 8'h00,              // no strings
    8'h01,                            // bNumConfigurations
    // configuration, at ROM_CONFIG_ADDR
    8'd9, 8'h02, 8'd27, 8'h00,        // wTotalLength covers all three
    8'h01, 8'h01, 8'h00, 8'hc0, 8'd50,
    // DFU interface, alternate 0
    8'd9, 8'h04, 8'h00, 8'h00, 8'h00,
    8'hfe, 8'h01, 8'h02, 8'h00,       // app specific, DFU, DFU mode
    // DFU functional
    8'd9, 8'h21, 8'h0d,               // download, manifest tolerant, detach
    8'hff, 8'h00,                     // wDetachTimeout
    8'(transfer_size),
    8'(transfer_size >> 8),
    8'h10, 8'h01,                     // bcdDFUVersion 1.1
    // language table, at ROM_LANG_ADDR
    8'd4, 8'h03, 8'h09, 8'h04         // US English
  };

  logic [7:0] addr;
  logic [7:0] len;
  logic       load_q;
  logic [7:0] rom_byte;

  assign rom_byte     = (addr < 8'(ROM_SIZE)) ? ROM[addr[5:0]] : 8'd0;
  assign data         = (plan.src == SRC_DFU) ? dfu_byte : rom_byte;
  assign dfu_addr     = addr[2:0];
  assign source_empty = len == 8'd0;

  always_ff @(posedge clk) begin
    if (reset) begin
      load_q <= 1'b0;
      addr   <= 8'd0;
      len    <= 8'd0;
    end else begin
      load_q <= setup_end;  // plan is valid one cycle after setup_end
      if (status_end) begin
        addr <= 8'd0;
        len  <= 8'd0;
      end else if (load_q) begin
        addr <= plan.addr;
        len  <= plan.len;
      end else if (byte_moved) begin
        addr <= addr + 8'd1;
        len  <= len - 8'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/request_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module request_decoder
  import dfu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  setup_pkt_u setup,
  input  logic       setup_end,
  input  logic       status_end,
  input  dfu_state_e dfu_state,
  output read_plan_t plan,
  output logic       stall,
  output dfu_event_t dfu_event,
  output logic [6:0] dev_addr
);

  setup_fields_t req;
  read_plan_t    plan_next;
  dfu_event_t    event_next;
  logic          stall_next;
  logic          set_addr;
  logic          dnload_ok;
  logic          addr_pending;
  logic [6:0]    new_addr;

  assign req       = setup.fields;
  assign dnload_ok = (dfu_state == DFU_IDLE) || (dfu_state == DFU_DNLOAD_IDLE);

  always_comb begin
    plan_next  = '{src: SRC_DESC, addr: 8'd0, len: 8'd0};
    event_next = EV_NONE;
    stall_next = 1'b0;
    set_addr   = 1'b0;
    case ({req.bm_request_type[6:5], req.b_request})
      REQ_GET_DESCRIPTOR: begin
        case (req.w_value[15:8])
          DESC_DEVICE: plan_next = '{src: SRC_DESC, addr: ROM_DEVICE_ADDR, len: 8'd18};
          DESC_CONFIG: plan_next = '{src: SRC_DESC, addr: ROM_CONFIG_ADDR, len: 8'd27};
          DESC_STRING: begin
            // only the language table, other indices answer empty
            if (req.w_value[7:0] == 8'd0) begin
              plan_next = '{src: SRC_DESC, addr: ROM_LANG_ADDR, len: 8'd4};
            end
          end
          DESC_QUALIFIER: stall_next = 1'b1;  // full speed only
          default: ;
        endcase
      end
      REQ_SET_ADDRESS: set_addr = 1'b1;
      REQ_SET_CONFIGURATION: ;  // single config, just ack
      REQ_DFU_DNLOAD: begin
        if (req.w_length != 16'd0 && dnload_ok) begin
          event_next = EV_DNLOAD_BLOCK;
        end else if (req.w_length == 16'd0 && dfu_state == DFU_DNLOAD_IDLE) begin
          event_next = EV_DNLOAD_FINAL;
        end else begin
          event_next = EV_DNLOAD_REJECT;
        end
      end
      REQ_DFU_GETSTATUS: begin
        plan_next  = '{src: SRC_DFU, addr: 8'd0, len: 8'd6};
        event_next = EV_GETSTATUS;
      end
      REQ_DFU_GETSTATE: plan_next = '{src: SRC_DFU, addr: 8'd4, len: 8'd1};
      REQ_DFU_CLRSTATUS: event_next = EV_CLRSTATUS;
      REQ_DFU_ABORT: event_next = EV_ABORT;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (setup_end) begin
      plan     <= plan_next;
      new_addr <= req.w_value[6:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stall        <= 1'b0;
      dfu_event    <= EV_NONE;
      addr_pending <= 1'b0;
      dev_addr     <= 7'd0;
    end else begin
      stall     <= setup_end && stall_next;
      dfu_event <= setup_end ? event_next : EV_NONE;
      if (setup_end && set_addr) begin
        addr_pending <= 1'b1;
      end else if (status_end && addr_pending) begin
        // status stage still ran on the old address
        addr_pending <= 1'b0;
        dev_addr     <= new_addr;
      end
    end
  end

endmodule

`default_nettype wire

/* design/setup_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module setup_capture
  import dfu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  out_ep_in_t out_ep,
  input  logic       status_end,
  output setup_pkt_u setup,
  output logic       pkt_start,
  output logic       pkt_end
);

  logic       avail_q;
  logic       byte_valid;  // setup byte on out_ep.data this cycle
  logic [2:0] byte_idx;

  assign pkt_start = out_ep.data_avail && !avail_q;
  assign pkt_end   = !out_ep.data_avail && avail_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      avail_q    <= 1'b0;
      byte_valid <= 1'b0;
      byte_idx   <= 3'd0;
    end else begin
      avail_q    <= out_ep.data_avail;
      byte_valid <= out_ep.data_avail && out_ep.grant && out_ep.setup;
      if (status_end) begin
        byte_idx <= 3'd0;  // next transfer starts at bmRequestType
      end else if (byte_valid) begin
        byte_idx <= byte_idx + 3'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_valid) begin
      setup.bytes[byte_idx] <= out_ep.data;
    end
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
design/dfu_pkg.sv
design/setup_capture.sv
design/ctrl_xfer_fsm.sv
design/request_decoder.sv
design/dfu_state_tracker.sv
design/in_data_source.sv
design/dfu_ctrl_ep.sv
sim/tb_dfu_ctrl_ep.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module tb_dfu_ctrl_ep -o sim_dfu > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/sim_dfu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0

/* include/tb_usb_host.svh */
`ifndef TB_USB_HOST_SVH
`define TB_USB_HOST_SVH

////////////////////////////////////////////////////////////////////////////
// host side of the control pipe
////////////////////////////////////////////////////////////////////////////

// 8 setup bytes; each byte follows its grant by one cycle
task automatic send_setup(input logic [7:0] bm, input logic [7:0] breq,
                          input logic [15:0] wvalue, input logic [15:0] wlength);
  logic [7:0] pkt [0:7];
  pkt[0] = bm;
  pkt[1] = breq;
  pkt[2] = wvalue[7:0];
  pkt[3] = wvalue[15:8];
  pkt[4] = 8'h00;  // wIndex unused here
  pkt[5] = 8'h00;
  pkt[6] = wlength[7:0];
  pkt[7] = wlength[15:8];
  for (int i = 0; i <= 8; i++) begin
    @(posedge clk);
    out_ep.data_avail <= (i < 8);
    out_ep.setup      <= (i < 8);
    out_ep.grant      <= (i < 8);
    if (i > 0) out_ep.data <= pkt[i-1];
  end
endtask

// out data stage bytes from the seeded generator
task automatic send_out(input int count);
  for (int i = 0; i < count; i++) begin
    @(posedge clk);
    out_ep.data_avail <= 1'b1;
    out_ep.setup      <= 1'b0;
    out_ep.grant      <= 1'b1;
    out_ep.data       <= 8'($random(seed));
  end
  @(posedge clk);
  out_ep.data_avail <= 1'b0;
  out_ep.grant      <= 1'b0;
endtask

// gather in bytes until data_done, or give up on a stall
task automatic collect_in();
  logic finished;
  finished  = 1'b0;
  rx_count  = 0;
  saw_stall = 1'b0;
  while (!finished) begin
    @(negedge clk);
    if (in_ep_out.stall) begin
      saw_stall = 1'b1;
      finished  = 1'b1;
    end else begin
      if (in_ep_out.data_put && in_ep_in.grant) begin
        if (rx_count < 32) rx_bytes[rx_count] = in_ep_out.data;
        rx_count++;
      end
      if (in_ep_out.data_done) finished = 1'b1;
    end
  end
endtask

task automatic ack_in();
  @(posedge clk);
  in_ep_in.acked <= 1'b1;
  @(posedge clk);
  in_ep_in.acked <= 1'b0;
endtask

task automatic ack_out();
  @(posedge clk);
  out_ep.acked <= 1'b1;
  @(posedge clk);
  out_ep.acked <= 1'b0;
endtask

`endif

/* sim/tb_dfu_ctrl_ep.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dfu_ctrl_ep
  import dfu_pkg::*;
;

  localparam int xfer_limit = 800;  // cycles allowed per transfer
  localparam int max_cycles = 16 + 25 * xfer_limit;

  logic       clk;
  logic       reset;
  out_ep_in_t out_ep;
  in_ep_in_t  in_ep_in;
  in_ep_out_t in_ep_out;
  logic       out_ep_req;
  logic       out_ep_data_get;
  logic [6:0] dev_addr;
  logic [7:0] dfu_state;

  integer     seed = 32'h0c48_f582;
  int         cycles = 0;
  int         errors = 0;
  int         test_errors_start;
  int         tests_run = 0;
  int         tests_failed = 0;
  logic [7:0] rx_bytes [0:31];
  int         rx_count;
  logic       saw_stall;
  logic [7:0] exp_bytes [0:31];
  logic       exp_care [0:31];
  int         exp_count;
  logic       exp_stall;
  logic [7:0] mdl_state;    // DFU state as the host expects it
  logic [7:0] mdl_status;
  event       resp_ready;

  dfu_ctrl_ep #(.max_packet_size(32), .transfer_size(256)) uut (
    .clk(clk), .reset(reset), .out_ep(out_ep), .in_ep_in(in_ep_in),
    .in_ep_out(in_ep_out), .out_ep_req(out_ep_req), .out_ep_data_get(out_ep_data_get),
    .dev_addr(dev_addr), .dfu_state(dfu_state)
  );

  always #50 clk = ~clk;

  `include "tb_usb_host.svh"

  ////////////////////////////////////////////////////////////////////////////
  // expected responses
  ////////////////////////////////////////////////////////////////////////////

  function automatic int expected_in(input logic [7:0] bm, input logic [7:0] breq,
                                     input logic [15:0] wvalue, input logic [15:0] wlength,
                                     input logic [7:0] state, input logic [7:0] status);
    int plan_len;
    plan_len  = 0;
    exp_stall = 1'b0;
    for (int i = 0; i < 32; i++) exp_care[i] = 1'b0;
    if (bm[7]) begin
      case ({bm[6:5], breq})
        10'h006: begin
          case (wvalue[15:8])
            8'd1: begin
              plan_len = 18;
              exp_bytes[0] = 8'd18;
              exp_care[0]  = 1'b1;
              exp_bytes[1] = 8'd1;
              exp_care[1]  = 1'b1;
              exp_bytes[7] = 8'd32;  // ep0 packet size
              exp_care[7]  = 1'b1;
            end
            8'd2: begin
              plan_len = 27;
              exp_bytes[0] = 8'd9;
              exp_care[0]  = 1'b1;
              exp_bytes[1] = 8'd2;
              exp_care[1]  = 1'b1;
              exp_bytes[2] = 8'd27;
              exp_care[2]  = 1'b1;
            end
            8'd3: if (wvalue[7:0] == 8'd0) begin
              plan_len = 4;
              exp_bytes[0] = 8'd4;
              exp_bytes[1] = 8'd3;
              exp_bytes[2] = 8'h09;
              exp_bytes[3] = 8'h04;
              for (int i = 0; i < 4; i++) exp_care[i] = 1'b1;
            end
            8'd6: exp_stall = 1'b1;
            default: plan_len = 0;
          endcase
        end
        10'h103: begin
          plan_len = 6;
          exp_bytes[0] = status;
          exp_bytes[1] = 8'd1;
          exp_bytes[2] = 8'd0;
          exp_bytes[3] = 8'd0;
          exp_bytes[4] = state;
          exp_bytes[5] = 8'd0;
          for (int i = 0; i < 6; i++) exp_care[i] = 1'b1;
        end
        10'h105: begin
          plan_len = 1;
          exp_bytes[0] = state;
          exp_care[0]  = 1'b1;
        end
        default: plan_len = 0;
      endcase
    end
    return (plan_len < int'(wlength)) ? plan_len : int'(wlength);
  endfunction

  // DFU state changes seen from the host
  // GETSTATUS moves the state before its reply
  task automatic update_model(input logic [7:0] bm, input logic [7:0] breq,
                              input logic [15:0] wlength);
    case ({bm[6:5], breq})
      10'h101: begin
        if (wlength != 0 && (mdl_state == 8'd2 || mdl_state == 8'd5)) begin
          mdl_state = 8'd3;
        end else if (wlength == 0 && mdl_state == 8'd5) begin
          mdl_state  = 8'd6;
          mdl_status = 8'd0;
        end else begin
          mdl_state  = 8'd10;
          mdl_status = 8'd3;
        end
      end
      10'h103: begin
        if (mdl_state == 8'd3) mdl_state = 8'd5;
        else if (mdl_state == 8'd6) mdl_state = 8'd2;
      end
      10'h104: begin
        mdl_state  = 8'd2;
        mdl_status = 8'd0;
      end
      10'h106: mdl_state = 8'd2;
      default: ;
    endcase
  endtask

  // one complete control transfer, then hand the result to the compare
  task automatic transfer(input logic [7:0] bm, input logic [7:0] breq,
                          input logic [15:0] wvalue, input logic [15:0] wlength);
    send_setup(bm, breq, wvalue, wlength);
    if (wlength != 0 && !bm[7]) begin
      repeat (3) @(posedge clk);
      send_out(int'(wlength));
    end
    collect_in();
    if (!saw_stall) begin
      ack_in();
      if (bm[7] && wlength != 0) ack_out();
    end
    repeat (2) @(posedge clk);
    update_model(bm, breq, wlength);
    exp_count = expected_in(bm, breq, wvalue, wlength, mdl_state, mdl_status);
    -> resp_ready;
    @(negedge clk);
  endtask

  always @(resp_ready) begin
    assert (saw_stall == exp_stall) else begin
      $display("[ERROR] %0t stall %0b, expected %0b", $time, saw_stall, exp_stall);
      errors++;
    end
    assert (rx_count == exp_count) else begin
      $display("[ERROR] %0t got %0d bytes, expected %0d", $time, rx_count, exp_count);
      errors++;
    end
    for (int i = 0; i < exp_count && i < rx_count; i++) begin
      if (exp_care[i]) begin
        assert (rx_bytes[i] == exp_bytes[i]) else begin
          $display("[ERROR] %0t byte %0d is %h, expected %h", $time, i, rx_bytes[i],
                   exp_bytes[i]);
          errors++;
        end
      end
    end
    assert (dfu_state == mdl_state) else begin
      $display("[ERROR] %0t dfu_state %0d, expected %0d", $time, dfu_state, mdl_state);
      errors++;
    end
  end

  // strobe rules that hold on every cycle
  always @(negedge clk) begin
    if (!reset) begin
      assert (out_ep_req == out_ep.data_avail) else begin
        $display("[ERROR] %0t out_ep_req %0b, expected %0b", $time, out_ep_req,
                 out_ep.data_avail);
        errors++;
      end
      assert (out_ep_data_get == out_ep.data_avail) else begin
        $display("[ERROR] %0t out_ep_data_get %0b, expected %0b", $time,
                 out_ep_data_get, out_ep.data_avail);
        errors++;
      end
      // data_free stays high, so a request always puts a byte
      assert (in_ep_out.req == in_ep_out.data_put) else begin
        $display("[ERROR] %0t in req %0b, expected %0b", $time, in_ep_out.req,
                 in_ep_out.data_put);
        errors++;
      end
    end
  end

  task automatic start_test();
    test_errors_start = errors;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_errors_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - test_errors_start);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    out_ep     = '0;
    in_ep_in   = '{grant: 1'b1, data_free: 1'b1, acked: 1'b0};
    mdl_state  = 8'd2;
    mdl_status = 8'd0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    repeat (2) @(posedge clk);

    start_test();
    transfer(8'h80, 8'h06, 16'h0100, 16'd64);
    transfer(8'h80, 8'h06, 16'h0200, 16'd9);
    transfer(8'h80, 8'h06, 16'h0300, 16'd255);
    finish_test("descriptors");

    start_test();
    send_setup(8'h00, 8'h05, 16'h002a, 16'd0);
    collect_in();
    assert (rx_count == 0 && !saw_stall) else begin
      $display("[ERROR] %0t set address sent %0d bytes, stall %0b, expected a zlp",
               $time, rx_count, saw_stall);
      errors++;
    end
    assert (dev_addr == 7'd0) else begin
      $display("[ERROR] %0t address changed before the status stage", $time);
      errors++;
    end
    ack_in();
    repeat (2) @(posedge clk);
    assert (dev_addr == 7'h2a) else begin
      $display("[ERROR] %0t dev_addr %h, expected 2a", $time, dev_addr);
      errors++;
    end
    transfer(8'h00, 8'h09, 16'h0001, 16'd0);  // zero-length status only
    finish_test("set_address");

    start_test();
    transfer(8'ha1, 8'h03, 16'h0000, 16'd6);
    transfer(8'ha1, 8'h05, 16'h0000, 16'd1);
    finish_test("getstatus_reset");

    start_test();
    transfer(8'h21, 8'h01, 16'h0000, 16'd16);
    transfer(8'ha1, 8'h03, 16'h0000, 16'd6);
    transfer(8'h21, 8'h01, 16'h0001, 16'd0);
    transfer(8'ha1, 8'h03, 16'h0000, 16'd6);
    transfer(8'ha1, 8'h03, 16'h0000, 16'd6);
    finish_test("dnload");

    start_test();
    transfer(8'h21, 8'h01, 16'h0000, 16'd16);
    transfer(8'h21, 8'h01, 16'h0001, 16'd16);  // rejected while still in sync
    transfer(8'ha1, 8'h03, 16'h0000, 16'd6);
    transfer(8'h21, 8'h04, 16'h0000, 16'd0);
    transfer(8'ha1, 8'h03, 16'h0000, 16'd6);
    transfer(8'h21, 8'h01, 16'h0000, 16'd16);
    transfer(8'ha1, 8'h03, 16'h0000, 16'd6);
    transfer(8'h21, 8'h06, 16'h0000, 16'd0);
    finish_test("dnload_errors");

    start_test();
    transfer(8'h80, 8'h06, 16'h0600, 16'd10);
    transfer(8'h40, 8'h77, 16'h0000, 16'd0);
    finish_test("stall_unknown");

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("Simulation failed");
      $finish;
    end
  end

endmodule

`default_nettype wire
